// ==== src.f ====
design/guitar_pkg.sv
design/oversampler.sv
design/frame_buffer.sv
design/audio_pwm.sv
design/apb_regs.sv
design/guitar_sampler_top.sv
verif/guitar_sampler_sva.sv
verif/guitar_sampler_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module guitar_sampler_tb -f src.f -o guitar_sampler_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/guitar_sampler_sim > sim.log 2>&1 || echo "Finished with errors" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

// ==== verif/guitar_sampler_tb.sv ====
`default_nettype none

module guitar_sampler_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 5;
    localparam int N_BLOCKS      = 3;
    localparam int BLOCK_LEN     = 256;         // Eoc strobes per 256x result
    localparam int SUB_BLOCK_LEN = 16;          // Eoc strobes per 16x result
    localparam int PWM_PERIOD    = 2048;
    // Eoc spacing is at most 4 cycles, each PWM check spans up to 3 periods
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (N_BLOCKS * BLOCK_LEN + SUB_BLOCK_LEN) * 4
                                  + 2 * 3 * PWM_PERIOD + 1000;

    ////////////////////////////////////////
    // Block table
    ////////////////////////////////////////
    // Constant converter word, then top 12 bits times 16 and times 4
    localparam logic [15:0] BLK_VALUE  [N_BLOCKS] = '{16'hA5C7, 16'h317B, 16'h7D35};
    localparam logic [15:0] BLK_EXP256 [N_BLOCKS] = '{16'hA5C0, 16'h3170, 16'h7D30};
    localparam logic [13:0] BLK_EXP16  [N_BLOCKS] = '{14'h2970, 14'h0C5C, 14'h1F4C};

    // One 16x block on its own so the two audio streams differ
    localparam logic [15:0] AUDIO_VALUE = 16'h2468;
    localparam logic [13:0] AUDIO_EXP16 = 14'h0918;    // 0x246 times 4

    logic        clk_104mhz;
    logic        rst_n;
    logic [15:0] adc_data;
    logic        adc_eoc;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         aud_pwm;
    wire         aud_sd;

    integer      seed = 32'h532c;               // Eoc spacing
    int          errors;
    int          checks;
    int          cycle_cnt;
    logic [10:0] pwm_phase;                     // Tracks the free running PWM count

    guitar_sampler_top u_guitar_sampler_top (
        .clk_104mhz (clk_104mhz),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_eoc    (adc_eoc),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .aud_pwm    (aud_pwm),
        .aud_sd     (aud_sd)
    );

    initial
    begin
        clk_104mhz = 1'b0;
        forever #10 clk_104mhz = ~clk_104mhz;   // 20 ns period
    end

    always @(posedge clk_104mhz)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // Counter starts at zero out of reset and wraps every period
    always @(posedge clk_104mhz)
    begin
        if (!rst_n)
            pwm_phase <= '0;
        else
            pwm_phase <= pwm_phase + 1'b1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////
    // Entered on a falling edge, returns on a falling edge
    task automatic bus_transfer(input logic wr, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err, output int waits);
        psel    = 1'b1;                         // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        waits   = 0;
        @(negedge clk_104mhz);
        penable = 1'b1;                         // Access phase
        while (!pready)
        begin
            @(negedge clk_104mhz);
            waits++;                            // Wait state
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_104mhz);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata,
                            output logic err, output int waits);
        bus_transfer(1'b0, addr, 32'h0, rdata, err, waits);
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] rdata;
        int          waits;
        bus_transfer(1'b1, addr, wdata, rdata, err, waits);
    endtask

    task automatic read_expect(input string name, input logic [15:0] addr,
                               input logic [31:0] exp, input int exp_waits);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_read(addr, rdata, err, waits);
        check_value(name, rdata, exp);
        check_value({name, " pslverr"}, err, 0);
        check_value({name, " wait states"}, waits, exp_waits);
    endtask

    // Poll HEAD until the frame write of the block has landed
    task automatic wait_for_head(input int blocks_done);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        int          polls;
        polls = 0;
        apb_read(guitar_pkg::REG_HEAD, rdata, err, waits);
        while (rdata != blocks_done && polls < 32)
        begin
            apb_read(guitar_pkg::REG_HEAD, rdata, err, waits);
            polls++;
        end
        checks++;
        assert (rdata == blocks_done)
        else
        begin
            errors++;
            $display("HEAD did not advance after block %0d was sent", blocks_done);
        end
    endtask

    ////////////////////////////////////////
    // Converter stream and PWM
    ////////////////////////////////////////
    task automatic send_block(input logic [15:0] value, input int len);
        int idle;
        adc_data = value;
        for (int n = 0; n < len; n++)
        begin
            adc_eoc = 1'b1;
            @(negedge clk_104mhz);
            adc_eoc = 1'b0;
            idle = $unsigned($random(seed)) % 4;    // 0 to 3 idle cycles
            repeat (idle) @(negedge clk_104mhz);
        end
    endtask

    task automatic count_high_cycles(output int highs);
        highs = 0;
        while (pwm_phase != 11'd1)              // Output of count zero is showing
            @(negedge clk_104mhz);
        repeat (PWM_PERIOD)
        begin
            if (aud_pwm)
                highs++;
            @(negedge clk_104mhz);
        end
    endtask

    initial
    begin
        logic [31:0] rdata;
        logic        err;
        int          waits;
        int          highs;
        int          sva_fails;
        rst_n     = 1'b0;
        adc_data  = '0;
        adc_eoc   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        repeat (RESET_CYCLES) @(posedge clk_104mhz);
        @(negedge clk_104mhz);
        rst_n = 1'b1;
        @(negedge clk_104mhz);

        // Reset state
        check_value("aud_sd", aud_sd, 1);
        read_expect("CTRL", guitar_pkg::REG_CTRL, 0, 0);
        read_expect("HEAD", guitar_pkg::REG_HEAD, 0, 0);
        read_expect("SAMPLE16", guitar_pkg::REG_SAMPLE16, 0, 0);
        read_expect("SAMPLE256", guitar_pkg::REG_SAMPLE256, 0, 0);

        for (int b = 0; b < N_BLOCKS; b++)
        begin
            send_block(BLK_VALUE[b], BLOCK_LEN);
            wait_for_head(b + 1);
            read_expect("SAMPLE256", guitar_pkg::REG_SAMPLE256, BLK_EXP256[b], 0);
            read_expect("SAMPLE16", guitar_pkg::REG_SAMPLE16, BLK_EXP16[b], 0);
        end

        // Frame window has one extra wait state
        for (int i = 0; i < N_BLOCKS; i++)
            read_expect("frame word", guitar_pkg::FRAME_BASE + 16'(4 * i), BLK_EXP256[i], 1);

        // Error responses
        apb_read(16'h0010, rdata, err, waits);
        check_value("pslverr unmapped read", err, 1);
        apb_write(guitar_pkg::REG_HEAD, 32'h1, err);
        check_value("pslverr HEAD write", err, 1);
        read_expect("CTRL after HEAD write", guitar_pkg::REG_CTRL, 0, 0);
        read_expect("HEAD after HEAD write", guitar_pkg::REG_HEAD, N_BLOCKS, 0);
        // Inside the frame window, so only the alignment rule flags it
        apb_read(guitar_pkg::FRAME_BASE + 16'h2, rdata, err, waits);
        check_value("pslverr misaligned read", err, 1);

        // New 16x value while the 256x value stays at the last block
        send_block(AUDIO_VALUE, SUB_BLOCK_LEN);

        // 16x stream, duty is bits 13 to 3
        apb_write(guitar_pkg::REG_CTRL, 32'h1, err);
        check_value("pslverr CTRL write", err, 0);
        count_high_cycles(highs);               // Skipped period
        count_high_cycles(highs);
        check_value("aud_pwm high cycles 16x", highs, AUDIO_EXP16[13:3]);

        // 256x stream, duty is bits 15 to 5
        apb_write(guitar_pkg::REG_CTRL, 32'h0, err);
        check_value("pslverr CTRL write", err, 0);
        count_high_cycles(highs);
        count_high_cycles(highs);
        check_value("aud_pwm high cycles 256x", highs, BLK_EXP256[N_BLOCKS-1][15:5]);

        sva_fails = u_guitar_sampler_top.u_sva.fail_cnt;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/guitar_sampler_sva.sv ====
`default_nettype none

module guitar_sampler_sva (
    input wire clk_104mhz,
    input wire rst_n,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr,
    input wire done16,
    input wire done256,
    input wire aud_sd
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;                  // Read by the testbench at the end

    ////////////////////////////////////////
    // APB handshake
    ////////////////////////////////////////
    pready_in_access: assert property (@(posedge clk_104mhz) disable iff (!rst_n)
        pready |-> (psel && penable))
    else
    begin
        fail_cnt++;
        $error("pready high outside an access phase");
    end

    pslverr_with_pready: assert property (@(posedge clk_104mhz) disable iff (!rst_n)
        pslverr |-> pready)                     // Error only flagged on completion
    else
    begin
        fail_cnt++;
        $error("pslverr high without pready");
    end

    ////////////////////////////////////////
    // Oversampler strobes
    ////////////////////////////////////////
    done16_single: assert property (@(posedge clk_104mhz) disable iff (!rst_n)
        done16 |=> !done16)
    else
    begin
        fail_cnt++;
        $error("16x done strobe longer than one cycle");
    end

    done256_single: assert property (@(posedge clk_104mhz) disable iff (!rst_n)
        done256 |=> !done256)                   // Also the frame write enable
    else
    begin
        fail_cnt++;
        $error("256x done strobe longer than one cycle");
    end

    // Amplifier stays in shutdown through reset
    sd_low_in_reset: assert property (@(posedge clk_104mhz)
        !rst_n |=> !aud_sd)
    else
    begin
        fail_cnt++;
        $error("aud_sd released while reset asserted");
    end

endmodule

bind guitar_sampler_top guitar_sampler_sva u_sva (
    .clk_104mhz (clk_104mhz),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .done16     (done16),
    .done256    (done256),
    .aud_sd     (aud_sd)
);

`default_nettype wire

// ==== design/guitar_sampler_top.sv ====
`default_nettype none

module guitar_sampler_top (
    input  wire                                 clk_104mhz,
    input  wire                                 rst_n,
    // Converter stream
    input  wire [guitar_pkg::ADC_WORD_W-1:0]    adc_data,
    input  wire                                 adc_eoc,    // One cycle per conversion
    // APB slave
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [guitar_pkg::APB_AW-1:0]        paddr,
    input  wire [guitar_pkg::APB_DW-1:0]        pwdata,
    output wire [guitar_pkg::APB_DW-1:0]        prdata,
    output wire                                 pready,
    output wire                                 pslverr,
    // Audio amplifier
    output wire                                 aud_pwm,
    output wire                                 aud_sd
);

    logic [guitar_pkg::OS16_W-1:0]   sample16;     // Audio rate stream
    logic                            done16;
    logic [guitar_pkg::OS256_W-1:0]  sample256;    // Analysis rate stream
    logic                            done256;
    logic [guitar_pkg::FRAME_AW-1:0] head;
    logic [guitar_pkg::FRAME_AW-1:0] frame_rd_addr;
    logic [guitar_pkg::OS256_W-1:0]  frame_rd_data;
    logic                            audio_sel;

    ////////////////////////////////////////
    // Oversampling chain
    ////////////////////////////////////////
    oversampler #(.OSR_LOG2(guitar_pkg::OSR16_LOG2)) u_os16 (
        .clk_104mhz (clk_104mhz),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_eoc    (adc_eoc),
        .sample     (sample16),
        .done       (done16)                    // Only status, nothing consumes it
    );

    oversampler #(.OSR_LOG2(guitar_pkg::OSR256_LOG2)) u_os256 (
        .clk_104mhz (clk_104mhz),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_eoc    (adc_eoc),
        .sample     (sample256),
        .done       (done256)
    );

    // Each 256x result goes into the frame
    frame_buffer u_frame (
        .clk_104mhz (clk_104mhz),
        .rst_n      (rst_n),
        .wr_en      (done256),
        .wr_data    (sample256),
        .rd_addr    (frame_rd_addr),
        .rd_data    (frame_rd_data),
        .head       (head)
    );

    audio_pwm u_pwm (
        .clk_104mhz (clk_104mhz),
        .rst_n      (rst_n),
        .audio_sel  (audio_sel),
        .sample16   (sample16),
        .sample256  (sample256),
        .aud_pwm    (aud_pwm),
        .aud_sd     (aud_sd)
    );

    ////////////////////////////////////////
    // Register access
    ////////////////////////////////////////
    apb_regs u_regs (
        .clk_104mhz    (clk_104mhz),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .head          (head),
        .sample16      (sample16),
        .sample256     (sample256),
        .frame_rd_data (frame_rd_data),
        .frame_rd_addr (frame_rd_addr),
        .audio_sel     (audio_sel)
    );

endmodule

`default_nettype wire

// ==== design/apb_regs.sv ====
`default_nettype none

module apb_regs (
    input  wire                                 clk_104mhz,
    input  wire                                 rst_n,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire [guitar_pkg::APB_AW-1:0]        paddr,
    input  wire [guitar_pkg::APB_DW-1:0]        pwdata,
    output logic [guitar_pkg::APB_DW-1:0]       prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire [guitar_pkg::FRAME_AW-1:0]      head,
    input  wire [guitar_pkg::OS16_W-1:0]        sample16,
    input  wire [guitar_pkg::OS256_W-1:0]       sample256,
    input  wire [guitar_pkg::OS256_W-1:0]       frame_rd_data,
    output logic [guitar_pkg::FRAME_AW-1:0]     frame_rd_addr,
    output logic                                audio_sel
);

    logic                           setup_phase;
    logic                           aligned;
    logic                           is_reg;
    logic                           is_frame;
    logic                           acc_err;
    logic                           ctrl_wr;
    logic                           frame_rd_req;
    logic                           frame_wait;     // Wait state for RAM latency
    logic [guitar_pkg::APB_AW-1:0]  frame_off;
    logic [guitar_pkg::APB_DW-1:0]  reg_rdata;
    logic [guitar_pkg::APB_DW-1:0]  frame_rdata;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign setup_phase = psel & ~penable;
    assign aligned     = (paddr[1:0] == 2'b00);
    assign frame_off   = paddr - guitar_pkg::FRAME_BASE;
    assign is_frame    = (paddr >= guitar_pkg::FRAME_BASE) &&
                         (frame_off < 4 * guitar_pkg::FRAME_DEPTH);

    // RAM address straight from the bus so data is ready in the access phase
    assign frame_rd_addr = frame_off[guitar_pkg::FRAME_AW+1:2];

    always_comb
    begin
        is_reg    = 1'b1;
        reg_rdata = '0;
        case (paddr)
            guitar_pkg::REG_CTRL:      reg_rdata[0] = audio_sel;
            guitar_pkg::REG_HEAD:      reg_rdata[guitar_pkg::FRAME_AW-1:0] = head;
            guitar_pkg::REG_SAMPLE16:  reg_rdata[guitar_pkg::OS16_W-1:0] = sample16;
            guitar_pkg::REG_SAMPLE256: reg_rdata[guitar_pkg::OS256_W-1:0] = sample256;
            default:                   is_reg = 1'b0;
        endcase
    end

    // Misaligned, unmapped, or a write anywhere but CTRL
    assign acc_err = ~aligned | (~is_reg & ~is_frame) |
                     (pwrite & (paddr != guitar_pkg::REG_CTRL));
    assign ctrl_wr      = pwrite & ~acc_err;        // Only CTRL survives the check
    assign frame_rd_req = is_frame & ~acc_err;      // Frame writes already flagged

    assign frame_rdata = {{(guitar_pkg::APB_DW - guitar_pkg::OS256_W){1'b0}}, frame_rd_data};

    ////////////////////////////////////////
    // Transfer control
    ////////////////////////////////////////
    always_ff @(posedge clk_104mhz)
    begin
        if (!rst_n)
        begin
            pready     <= 1'b0;
            pslverr    <= 1'b0;
            frame_wait <= 1'b0;
            audio_sel  <= 1'b0;             // 256x stream after reset
        end
        else
        begin
            pready  <= 1'b0;                // Single cycle completion
            pslverr <= 1'b0;
            if (setup_phase)
            begin
                if (frame_rd_req)
                begin
                    frame_wait <= 1'b1;     // RAM output lands next cycle
                end
                else
                begin
                    pready  <= 1'b1;        // First access cycle
                    pslverr <= acc_err;
                    if (ctrl_wr)
                        audio_sel <= pwdata[0];
                end
            end
            else if (frame_wait)
            begin
                frame_wait <= 1'b0;
                pready     <= 1'b1;         // Second access cycle
            end
        end
    end

    // Read data, valid alongside pready
    always_ff @(posedge clk_104mhz)
    begin
        if (setup_phase && !frame_rd_req)
            prdata <= acc_err ? '0 : reg_rdata;
        else if (frame_wait)
            prdata <= frame_rdata;
    end

endmodule

`default_nettype wire

// ==== design/audio_pwm.sv ====
`default_nettype none

module audio_pwm (
    input  wire                                 clk_104mhz,
    input  wire                                 rst_n,
    input  wire                                 audio_sel,  // 1 plays 16x
    input  wire [guitar_pkg::OS16_W-1:0]        sample16,
    input  wire [guitar_pkg::OS256_W-1:0]       sample256,
    output logic                                aud_pwm,
    output logic                                aud_sd
);

    logic [guitar_pkg::PWM_W-1:0] pwm_cnt;      // Free running period counter
    logic [guitar_pkg::PWM_W-1:0] duty;         // Held for a whole period
    logic [guitar_pkg::PWM_W-1:0] next_duty;

    // Top PWM_W bits of the chosen stream
    assign next_duty = audio_sel ? sample16[guitar_pkg::OS16_W-1 -: guitar_pkg::PWM_W]
                                 : sample256[guitar_pkg::OS256_W-1 -: guitar_pkg::PWM_W];

    always_ff @(posedge clk_104mhz)
    begin
        if (!rst_n)
        begin
            pwm_cnt <= '0;
            duty    <= '0;
            aud_pwm <= 1'b0;
            aud_sd  <= 1'b0;                    // Amplifier held in shutdown
        end
        else
        begin
            pwm_cnt <= pwm_cnt + 1'b1;          // Wraps every 2048 cycles
            if (&pwm_cnt)
                duty <= next_duty;              // New duty from count zero on
            aud_pwm <= (pwm_cnt < duty);        // Exactly duty high cycles per period
            aud_sd  <= 1'b1;                    // Release once out of reset
        end
    end

    // Output is registered so the pin sees no compare glitches
    // A duty of zero keeps the output low for the whole period

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
`default_nettype none

module frame_buffer (
    input  wire                                 clk_104mhz,
    input  wire                                 rst_n,
    input  wire                                 wr_en,
    input  wire [guitar_pkg::OS256_W-1:0]       wr_data,
    input  wire [guitar_pkg::FRAME_AW-1:0]      rd_addr,
    output logic [guitar_pkg::OS256_W-1:0]      rd_data,
    output logic [guitar_pkg::FRAME_AW-1:0]     head
);

    ////////////////////////////////////////
    // Simple dual port frame RAM
    ////////////////////////////////////////
    logic [guitar_pkg::OS256_W-1:0] mem [guitar_pkg::FRAME_DEPTH];

    always_ff @(posedge clk_104mhz)
    begin
        if (wr_en)
            mem[head] <= wr_data;               // Newest sample at the head
        rd_data <= mem[rd_addr];                // One cycle read latency
    end

    // Write head points at the next free slot
    // Natural wrap at FRAME_DEPTH since the counter is FRAME_AW bits
    always_ff @(posedge clk_104mhz)
    begin
        if (!rst_n)
        begin
            head <= '0;
        end
        else if (wr_en)
        begin
            head <= head + 1'b1;                // Same edge as the write
        end
    end

    // Oldest sample sits at the head once the buffer has wrapped
    // Readers walk forward from head to get a time ordered frame

endmodule

`default_nettype wire

// ==== design/oversampler.sv ====
`default_nettype none

module oversampler #(
    parameter int OSR_LOG2 = 4                  // Block length is 2**OSR_LOG2 samples
) (
    input  wire                                         clk_104mhz,
    input  wire                                         rst_n,
    input  wire [guitar_pkg::ADC_WORD_W-1:0]            adc_data,
    input  wire                                         adc_eoc,
    output logic [guitar_pkg::ADC_BITS+OSR_LOG2/2-1:0]  sample,
    output logic                                        done
);

    // Sum of a full block needs OSR_LOG2 extra bits
    localparam int ACC_W = guitar_pkg::ADC_BITS + OSR_LOG2;

    logic [guitar_pkg::ADC_BITS-1:0] adc_top;   // Valid converter bits
    logic [ACC_W-1:0]                adc_ext;
    logic [OSR_LOG2-1:0]             cnt;       // Samples taken in this block
    logic [ACC_W-1:0]                acc;
    logic [ACC_W-1:0]                sum_q;     // Finished block sum
    logic                            last_eoc;
    logic                            last_q;

    assign adc_top  = adc_data[guitar_pkg::ADC_WORD_W-1 -: guitar_pkg::ADC_BITS];
    assign adc_ext  = {{OSR_LOG2{1'b0}}, adc_top};
    assign last_eoc = adc_eoc & (&cnt);         // Final sample of the block

    always_ff @(posedge clk_104mhz)
    begin
        if (!rst_n)
        begin
            cnt    <= '0;
            acc    <= '0;
            last_q <= 1'b0;
            done   <= 1'b0;
            sample <= '0;
        end
        else
        begin
            if (adc_eoc)
            begin
                cnt <= cnt + 1'b1;              // Wraps at the block size
                acc <= last_eoc ? '0 : acc + adc_ext;   // Restart on block end
            end
            last_q <= last_eoc;
            done   <= last_q;                   // One cycle after the last eoc edge
            if (last_q)
                sample <= sum_q[ACC_W-1:OSR_LOG2/2];    // Keep half the gain bits
        end
    end

    // Block total, captured with the last sample
    always_ff @(posedge clk_104mhz)
    begin
        if (last_eoc)
            sum_q <= acc + adc_ext;
    end

endmodule

`default_nettype wire

// ==== design/guitar_pkg.sv ====
`default_nettype none

package guitar_pkg;

    ////////////////////////////////////////
    // Converter and oversampling
    ////////////////////////////////////////
    localparam int ADC_WORD_W  = 16;    // Raw converter word
    localparam int ADC_BITS    = 12;    // Valid bits sit at the top of the word
    localparam int OSR16_LOG2  = 4;     // 16x gives about 62.5 kHz at 1 Msps
    localparam int OSR256_LOG2 = 8;     // 256x gives about 3.9 kHz
    localparam int OS16_W      = 14;    // 12 bits plus 2 bits of averaging gain
    localparam int OS256_W     = 16;    // 12 bits plus 4 bits of averaging gain

    // Frame memory holds one 256x frame
    localparam int FRAME_DEPTH = 4096;
    localparam int FRAME_AW    = 12;

    // 2048 cycle PWM period gives about 51 kHz from clk_104mhz
    localparam int PWM_W = 11;

    ////////////////////////////////////////
    // APB map
    ////////////////////////////////////////
    localparam int APB_AW = 16;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_CTRL      = 16'h0000;    // Bit 0 selects audio stream
    localparam logic [APB_AW-1:0] REG_HEAD      = 16'h0004;    // Frame write head
    localparam logic [APB_AW-1:0] REG_SAMPLE16  = 16'h0008;    // Latest 16x value
    localparam logic [APB_AW-1:0] REG_SAMPLE256 = 16'h000C;    // Latest 256x value

    // Word i of the frame at FRAME_BASE + 4*i
    localparam logic [APB_AW-1:0] FRAME_BASE    = 16'h4000;

endpackage

`default_nettype wire
